// File: source/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// integer data path and byte address width
`define RV_XLEN 32

// architectural integer registers, x0 included
`define RV_NUM_REGS 32

// data memory size in words
// the word index wraps at this depth
`define RV_DMEM_WORDS 256

// cycles from a new memory request to the mem_ready pulse
// any value of 1 or more works
`define RV_DMEM_LATENCY 2

`endif

// File: source/rv_isa_pkg.sv
`include "rv_settings.svh"

package rv_isa_pkg;

  // one data word on the integer data path
  typedef logic [`RV_XLEN-1:0] word_t;

  // byte address, same width as a data word
  typedef logic [`RV_XLEN-1:0] addr_t;

  // index into the integer register file
  typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_idx_t;

  // one write-enable bit per byte lane
  typedef logic [`RV_XLEN/8-1:0] strb_t;

  // load and store operations handled by the memory stage
  typedef enum logic [2:0] {
    op_lw,
    op_lh,
    op_lhu,
    op_lb,
    op_lbu,
    op_sw,
    op_sh,
    op_sb
  } mem_op_t;

endpackage

// File: source/rv_stage_pkg.sv
package rv_stage_pkg;

  // accessor control states
  // st_idle waits for a request from the executor side
  // st_wait_mem holds the memory request until mem_ready
  // st_hold_out presents the result until the fetcher side takes it
  typedef enum logic [1:0] {
    st_idle,
    st_wait_mem,
    st_hold_out
  } acc_state_t;

endpackage

// File: source/register_file.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module register_file (
  input  var logic                  clk,
  input  var logic                  reset,
  input  var rv_isa_pkg::reg_idx_t  rf_raddr,
  input  var logic                  rf_we,
  input  var rv_isa_pkg::reg_idx_t  rf_waddr,
  input  var rv_isa_pkg::word_t     rf_wdata,
  output var rv_isa_pkg::word_t     rf_rdata
);

  rv_isa_pkg::word_t regs [`RV_NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_we && rf_waddr != '0) begin
      regs[rf_waddr] <= rf_wdata;
    end
  end

  // combinational read, a write shows from the next cycle on
  // x0 is hardwired to zero
  assign rf_rdata = (rf_raddr == '0) ? '0 : regs[rf_raddr];

endmodule

// File: source/data_memory.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module data_memory (
  input  var logic               clk,
  input  var logic               reset,
  input  var logic               mem_valid,
  input  var rv_isa_pkg::addr_t  mem_addr,
  input  var rv_isa_pkg::strb_t  mem_wstrb,
  input  var rv_isa_pkg::word_t  mem_wdata,
  output var logic               mem_ready,
  output var rv_isa_pkg::word_t  mem_rdata
);

  localparam int idx_w = $clog2(`RV_DMEM_WORDS);
  localparam int cnt_w = $clog2(`RV_DMEM_LATENCY + 1);

  rv_isa_pkg::word_t mem [`RV_DMEM_WORDS];

  logic [idx_w-1:0] idx;
  logic             busy;
  logic [cnt_w-1:0] cnt;
  logic [cnt_w-1:0] next_cnt;
  logic             start;
  logic             fire;

  // word index, byte offset dropped
  assign idx = idx_w'((mem_addr >> 2) % `RV_DMEM_WORDS);

  // mem_valid is still high during the response cycle, so skip it
  assign start    = mem_valid && !busy && !mem_ready;
  assign next_cnt = start ? cnt_w'(1) : cnt + 1'b1;
  assign fire     = (start || busy) && (next_cnt == cnt_w'(`RV_DMEM_LATENCY));

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      cnt       <= '0;
      mem_ready <= 1'b0;
    end else begin
      mem_ready <= fire;
      busy      <= (start || busy) && !fire;
      if (fire) begin
        cnt <= '0;
      end else if (start || busy) begin
        cnt <= next_cnt;
      end
    end
  end

  // read returns the word as it was before this request's write
  always_ff @(posedge clk) begin
    if (fire) begin
      mem_rdata <= mem[idx];
      for (int b = 0; b < $bits(rv_isa_pkg::strb_t); b++) begin
        if (mem_wstrb[b]) begin
          mem[idx][8*b +: 8] <= mem_wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: source/accessor.sv
`timescale 1ns/1ps

module accessor (
  input  var logic                  clk,
  input  var logic                  reset,
  // executor side
  input  var logic                  exec_valid,
  input  var rv_isa_pkg::mem_op_t   exec_op,
  input  var rv_isa_pkg::addr_t     exec_addr,
  input  var rv_isa_pkg::reg_idx_t  exec_rs2,
  input  var rv_isa_pkg::reg_idx_t  exec_rd,
  output var logic                  acc_ready,
  // fetcher side
  input  var logic                  fetch_ready,
  output var logic                  acc_valid,
  output var rv_isa_pkg::reg_idx_t  res_rd,
  output var rv_isa_pkg::word_t     res_data,
  output var logic                  res_trap,
  // data memory
  input  var logic                  mem_ready,
  input  var rv_isa_pkg::word_t     mem_rdata,
  output var logic                  mem_valid,
  output var rv_isa_pkg::addr_t     mem_addr,
  output var rv_isa_pkg::strb_t     mem_wstrb,
  output var rv_isa_pkg::word_t     mem_wdata,
  // register file
  input  var rv_isa_pkg::word_t     rf_rdata,
  output var rv_isa_pkg::reg_idx_t  rf_raddr,
  output var logic                  rf_we,
  output var rv_isa_pkg::reg_idx_t  rf_waddr,
  output var rv_isa_pkg::word_t     rf_wdata
);

  rv_stage_pkg::acc_state_t state;
  rv_isa_pkg::mem_op_t      op_q;
  logic [1:0]               offset_q;

  logic                     accept;
  logic                     misaligned;
  rv_isa_pkg::strb_t        store_strb;
  rv_isa_pkg::word_t        store_data;
  rv_isa_pkg::word_t        shifted;
  rv_isa_pkg::word_t        load_data;

  function automatic logic is_load(input rv_isa_pkg::mem_op_t op);
    return op inside {rv_isa_pkg::op_lw, rv_isa_pkg::op_lh, rv_isa_pkg::op_lhu,
                      rv_isa_pkg::op_lb, rv_isa_pkg::op_lbu};
  endfunction

  // acc_ready is only ever high in st_idle
  assign accept = exec_valid && acc_ready;

  // store data comes straight from the register file in the accept cycle
  assign rf_raddr = exec_rs2;

  // writeback reuses the result registers and rf_we qualifies them
  assign rf_waddr = res_rd;
  assign rf_wdata = res_data;

  always_comb begin
    unique case (exec_op)
      rv_isa_pkg::op_lw, rv_isa_pkg::op_sw: misaligned = |exec_addr[1:0];
      rv_isa_pkg::op_lh, rv_isa_pkg::op_lhu, rv_isa_pkg::op_sh: misaligned = exec_addr[0];
      default: misaligned = 1'b0;
    endcase
  end

  // store bytes go to every lane and the strobes pick the live ones
  always_comb begin
    store_strb = '0;
    store_data = '0;
    unique case (exec_op)
      rv_isa_pkg::op_sw: begin
        store_strb = 4'b1111;
        store_data = rf_rdata;
      end
      rv_isa_pkg::op_sh: begin
        store_strb = exec_addr[1] ? 4'b1100 : 4'b0011;
        store_data = {2{rf_rdata[15:0]}};
      end
      rv_isa_pkg::op_sb: begin
        store_strb = 4'b0001 << exec_addr[1:0];
        store_data = {4{rf_rdata[7:0]}};
      end
      default: ;
    endcase
  end

  // bring the addressed lane down to bit 0 and then extend
  assign shifted = mem_rdata >> {offset_q, 3'b000};

  always_comb begin
    unique case (op_q)
      rv_isa_pkg::op_lw:  load_data = shifted;
      rv_isa_pkg::op_lh:  load_data = rv_isa_pkg::word_t'($signed(shifted[15:0]));
      rv_isa_pkg::op_lhu: load_data = rv_isa_pkg::word_t'(shifted[15:0]);
      rv_isa_pkg::op_lb:  load_data = rv_isa_pkg::word_t'($signed(shifted[7:0]));
      rv_isa_pkg::op_lbu: load_data = rv_isa_pkg::word_t'(shifted[7:0]);
      // stores report zero
      default:            load_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= rv_stage_pkg::st_idle;
      acc_ready <= 1'b0;
      acc_valid <= 1'b0;
      mem_valid <= 1'b0;
      rf_we     <= 1'b0;
    end else begin
      // writeback is a single-cycle pulse
      rf_we <= 1'b0;
      unique case (state)
        rv_stage_pkg::st_idle: begin
          if (accept) begin
            acc_ready <= 1'b0;
            if (misaligned) begin
              // no memory access and the trap is reported right away
              acc_valid <= 1'b1;
              state     <= rv_stage_pkg::st_hold_out;
            end else begin
              mem_valid <= 1'b1;
              state     <= rv_stage_pkg::st_wait_mem;
            end
          end else begin
            acc_ready <= 1'b1;
          end
        end
        rv_stage_pkg::st_wait_mem: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            acc_valid <= 1'b1;
            // x0 is never written
            rf_we     <= is_load(op_q) && (res_rd != '0);
            state     <= rv_stage_pkg::st_hold_out;
          end
        end
        rv_stage_pkg::st_hold_out: begin
          if (fetch_ready) begin
            acc_valid <= 1'b0;
            acc_ready <= 1'b1;
            state     <= rv_stage_pkg::st_idle;
          end
        end
        default: state <= rv_stage_pkg::st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q      <= exec_op;
      offset_q  <= exec_addr[1:0];
      res_rd    <= exec_rd;
      res_trap  <= misaligned;
      res_data  <= '0;
      mem_addr  <= exec_addr & ~rv_isa_pkg::addr_t'(2'b11);
      mem_wstrb <= store_strb;
      mem_wdata <= store_data;
    end else if (state == rv_stage_pkg::st_wait_mem && mem_ready) begin
      res_data <= load_data;
    end
  end

endmodule

// File: source/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top (
  input  var logic                  clk,
  input  var logic                  reset,
  // executor side
  input  var logic                  exec_valid,
  input  var rv_isa_pkg::mem_op_t   exec_op,
  input  var rv_isa_pkg::addr_t     exec_addr,
  input  var rv_isa_pkg::reg_idx_t  exec_rs2,
  input  var rv_isa_pkg::reg_idx_t  exec_rd,
  output var logic                  acc_ready,
  // fetcher side
  input  var logic                  fetch_ready,
  output var logic                  acc_valid,
  output var rv_isa_pkg::reg_idx_t  res_rd,
  output var rv_isa_pkg::word_t     res_data,
  output var logic                  res_trap
);

  // accessor to data memory
  logic                  mem_valid;
  rv_isa_pkg::addr_t     mem_addr;
  rv_isa_pkg::strb_t     mem_wstrb;
  rv_isa_pkg::word_t     mem_wdata;
  logic                  mem_ready;
  rv_isa_pkg::word_t     mem_rdata;

  // accessor to register file
  rv_isa_pkg::reg_idx_t  rf_raddr;
  rv_isa_pkg::word_t     rf_rdata;
  logic                  rf_we;
  rv_isa_pkg::reg_idx_t  rf_waddr;
  rv_isa_pkg::word_t     rf_wdata;

  accessor accessor_i (
    .clk         (clk),
    .reset       (reset),
    .exec_valid  (exec_valid),
    .exec_op     (exec_op),
    .exec_addr   (exec_addr),
    .exec_rs2    (exec_rs2),
    .exec_rd     (exec_rd),
    .acc_ready   (acc_ready),
    .fetch_ready (fetch_ready),
    .acc_valid   (acc_valid),
    .res_rd      (res_rd),
    .res_data    (res_data),
    .res_trap    (res_trap),
    .mem_ready   (mem_ready),
    .mem_rdata   (mem_rdata),
    .mem_valid   (mem_valid),
    .mem_addr    (mem_addr),
    .mem_wstrb   (mem_wstrb),
    .mem_wdata   (mem_wdata),
    .rf_rdata    (rf_rdata),
    .rf_raddr    (rf_raddr),
    .rf_we       (rf_we),
    .rf_waddr    (rf_waddr),
    .rf_wdata    (rf_wdata)
  );

  data_memory data_memory_i (
    .clk       (clk),
    .reset     (reset),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wstrb (mem_wstrb),
    .mem_wdata (mem_wdata),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata)
  );

  register_file register_file_i (
    .clk      (clk),
    .reset    (reset),
    .rf_raddr (rf_raddr),
    .rf_we    (rf_we),
    .rf_waddr (rf_waddr),
    .rf_wdata (rf_wdata),
    .rf_rdata (rf_rdata)
  );

endmodule

// File: test/mem_stage_tb.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module mem_stage_tb;

  localparam int wait_limit = 100;

  logic                 clk;
  logic                 reset;
  logic                 exec_valid;
  rv_isa_pkg::mem_op_t  exec_op;
  rv_isa_pkg::addr_t    exec_addr;
  rv_isa_pkg::reg_idx_t exec_rs2;
  rv_isa_pkg::reg_idx_t exec_rd;
  logic                 acc_ready;
  logic                 fetch_ready;
  logic                 acc_valid;
  rv_isa_pkg::reg_idx_t res_rd;
  rv_isa_pkg::word_t    res_data;
  logic                 res_trap;

  int          errors;
  int          cases_run;
  int          cases_failed;
  int          transfers;
  logic        timed_out;
  logic [31:0] rng;

  mem_stage_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // random back-pressure with ready about three cycles in four
  initial begin
    rng = 32'd98;
    fetch_ready = 1'b0;
    forever begin
      @(posedge clk);
      rng = xorshift32(rng);
      fetch_ready <= (rng[1:0] != 2'b00);
    end
  end

  // a result leaves on the edge after a cycle with acc_valid and fetch_ready
  always @(negedge clk) begin
    if (!reset && acc_valid && fetch_ready) begin
      transfers = transfers + 1;
    end
  end

  task automatic run_case(input int num, input rv_isa_pkg::mem_op_t op,
                          input rv_isa_pkg::addr_t addr, input int rs2, input int rd,
                          input rv_isa_pkg::word_t exp_data, input logic exp_trap);
    int                   cycles;
    logic                 ok;
    logic                 held;
    rv_isa_pkg::word_t    held_data;
    logic                 held_trap;
    rv_isa_pkg::reg_idx_t held_rd;
    ok = 1'b1;
    held = 1'b0;
    held_data = '0;
    held_trap = 1'b0;
    held_rd = '0;
    @(posedge clk);
    exec_valid <= 1'b1;
    exec_op    <= op;
    exec_addr  <= addr;
    exec_rs2   <= rv_isa_pkg::reg_idx_t'(rs2);
    exec_rd    <= rv_isa_pkg::reg_idx_t'(rd);
    // acc_ready seen mid-cycle means the request goes on the coming edge
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!acc_ready && cycles < wait_limit);
    if (!acc_ready) begin
      $display("timeout: case %0d was never accepted", num);
      timed_out = 1'b1;
      return;
    end
    @(posedge clk);
    exec_valid <= 1'b0;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      assert (!acc_ready) else begin
        $display("[ERROR] %0t: acc_ready high while case %0d is in flight", $time, num);
        ok = 1'b0;
      end
      if (held) begin
        assert (acc_valid && res_data === held_data && res_trap === held_trap &&
                res_rd === held_rd) else begin
          $display("[ERROR] %0t: result of case %0d changed under back-pressure", $time, num);
          ok = 1'b0;
        end
      end
      held      = held | acc_valid;
      held_data = res_data;
      held_trap = res_trap;
      held_rd   = res_rd;
    end while (!(acc_valid && fetch_ready) && cycles < wait_limit);
    if (!(acc_valid && fetch_ready)) begin
      $display("timeout: no result was taken for case %0d", num);
      timed_out = 1'b1;
      return;
    end
    assert (res_data === exp_data && res_trap === exp_trap &&
            res_rd === rv_isa_pkg::reg_idx_t'(rd)) else begin
      $display("[ERROR] %0t: case %0d got data %h trap %b rd %0d, expected %h %b %0d",
               $time, num, res_data, res_trap, res_rd, exp_data, exp_trap, rd);
      ok = 1'b0;
    end
    // the result leaves on this edge
    @(posedge clk);
    assert (transfers == num) else begin
      $display("[ERROR] %0t: %0d result transfers after %0d cases", $time, transfers, num);
      ok = 1'b0;
    end
    $display("case %0d %s addr %h: %s", num, op.name(), addr, ok ? "ok" : "mismatch");
    if (!ok) begin
      cases_failed++;
    end
  endtask

  initial begin
    int                fd;
    int                n;
    int                op_num;
    int                rs2;
    int                rd;
    int                trap;
    string             line;
    rv_isa_pkg::addr_t addr;
    rv_isa_pkg::word_t exp_data;
    reset        = 1'b1;
    exec_valid   = 1'b0;
    exec_op      = rv_isa_pkg::op_lw;
    exec_addr    = '0;
    exec_rs2     = '0;
    exec_rd      = '0;
    errors       = 0;
    cases_run    = 0;
    cases_failed = 0;
    transfers    = 0;
    timed_out    = 1'b0;
    // every word starts distinct and the expected loads in the cases file follow this fill
    for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
      dut_i.data_memory_i.mem[i] = {4{8'(i)}} ^ 32'h8c7e_f301;
    end
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    fd = $fopen("test/mem_stage_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open test/mem_stage_cases.txt");
      errors++;
    end
    while (fd != 0 && !timed_out && $fgets(line, fd) != 0) begin
      if (line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%d %h %d %d %h %d", op_num, addr, rs2, rd, exp_data, trap);
      if (n == 6 && op_num >= 0 && op_num <= 7) begin
        cases_run++;
        run_case(cases_run, rv_isa_pkg::mem_op_t'(op_num), addr, rs2, rd, exp_data, trap[0]);
      end else if (n > 0) begin
        $display("unreadable line in cases file: %s", line);
        errors++;
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    $display("%0d cases run, %0d failed, %0d other errors", cases_run, cases_failed, errors);
    if (!timed_out && cases_run > 0 && cases_failed == 0 && errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: test/mem_stage_cases.txt
# op (0 lw 1 lh 2 lhu 3 lb 4 lbu 5 sw 6 sh 7 sb), byte address, rs2, rd, expected data, trap
# data memory word i starts as {4{i[7:0]}} ^ 8c7ef301, registers start at zero
5 00000010 0 0 00000000 0
0 00000010 0 1 00000000 0
0 00000000 0 1 8c7ef301 0
3 00000000 0 2 00000001 0
3 00000001 0 2 fffffff3 0
3 00000002 0 2 0000007e 0
3 00000003 0 2 ffffff8c 0
4 00000001 0 2 000000f3 0
4 00000003 0 2 0000008c 0
1 00000000 0 2 fffff301 0
1 00000002 0 2 ffff8c7e 0
2 00000000 0 2 0000f301 0
2 00000002 0 2 00008c7e 0
# partial stores into word 1 (8d7ff200) from x1 and x2
7 00000005 1 0 00000000 0
6 00000006 1 0 00000000 0
0 00000004 0 3 f3010100 0
7 00000007 2 0 00000000 0
6 00000004 2 0 00000000 0
0 00000004 0 3 7e018c7e 0
# misaligned accesses around word 2 (8e7cf103)
0 00000009 0 4 00000000 1
1 0000000b 0 4 00000000 1
2 00000009 0 4 00000000 1
5 0000000a 1 0 00000000 1
6 0000000b 1 0 00000000 1
0 00000008 0 4 8e7cf103 0
# writeback through rd, x0 keeps reading zero
0 00000040 0 7 9c6ee311 0
5 00000080 7 0 00000000 0
0 00000080 0 8 9c6ee311 0
0 00000100 0 0 cc3eb341 0
5 00000084 0 0 00000000 0
0 00000084 0 9 00000000 0

// File: mem_stage_top.f
+incdir+source
source/rv_isa_pkg.sv
source/rv_stage_pkg.sv
source/register_file.sv
source/data_memory.sv
source/accessor.sv
source/mem_stage_top.sv
test/mem_stage_tb.sv

// File: Bender.yml
package:
  name: mem_stage

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/rv_isa_pkg.sv
      - source/rv_stage_pkg.sv
      - source/register_file.sv
      - source/data_memory.sv
      - source/accessor.sv
      - source/mem_stage_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/mem_stage_tb.sv
